// File: isa_pkg.sv
// integer ISA definitions
package isa_pkg;

    // data path width
    localparam int unsigned xlen = 32;

    // tag width of the reorder buffer, 8 entries by default
    localparam int unsigned rob_tag_width = 3;

    typedef logic [4:0] reg_idx_t;

    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_xor  = 3'd2,
        op_mul  = 3'd3,
        op_bnez = 3'd4,
        op_halt = 3'd5
    } op_t;

    // one finished result from an execution lane
    typedef struct packed {
        logic [rob_tag_width-1:0] tag;
        logic [xlen-1:0]          value;
        logic                     taken;
        logic [xlen-1:0]          target;
    } lane_result_t;

endpackage

// File: rob_pkg.sv
// reorder buffer types
package rob_pkg;

    // entry index, doubles as the instruction tag
    typedef logic [isa_pkg::rob_tag_width-1:0] rob_tag_t;

    // operation sent from the issue queue to a lane
    typedef struct packed {
        rob_tag_t                 tag;
        isa_pkg::op_t             op;
        logic [isa_pkg::xlen-1:0] a;
        logic [isa_pkg::xlen-1:0] b;
        logic [isa_pkg::xlen-1:0] pc;
    } issue_packet_t;

    // one slot of the circular buffer
    typedef struct packed {
        logic                     valid;
        logic                     ready;
        logic [isa_pkg::xlen-1:0] pc;
        isa_pkg::reg_idx_t        dest;
        logic [isa_pkg::xlen-1:0] value;
        // only set for branches
        logic                     pred_taken;
        logic                     mispred;
        logic [isa_pkg::xlen-1:0] target;
        logic                     halt;
    } rob_entry_t;

endpackage

// File: backend_ifs.sv
// back end interfaces

// issue queue to one execution lane
interface exec_if;
    logic                   valid;
    rob_pkg::issue_packet_t packet;
    logic                   idle;

    modport sender (
        output valid,
        output packet,
        input  idle
    );

    modport lane (
        input  valid,
        input  packet,
        output idle
    );
endinterface

// lane results, arbiter and the common data bus
interface cdb_if #(
    parameter int unsigned lane_count = 2
);
    logic                  pending   [lane_count];
    isa_pkg::lane_result_t lane_data [lane_count];
    logic                  grant     [lane_count];
    logic                  bus_valid;
    isa_pkg::lane_result_t bus_data;

    modport lane (output pending, output lane_data, input grant);
    modport arbiter (input pending, input lane_data, output grant, output bus_valid, output bus_data);
    modport sink (input bus_valid, input bus_data);
endinterface

// File: fifo_buffer.sv
// synchronous FIFO with flush
module fifo_buffer #(
    parameter int unsigned depth = 4,
    parameter type         payload_t = logic [7:0]
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);
    localparam int unsigned ptr_width = (depth > 1) ? $clog2(depth) : 1;

    typedef logic [ptr_width-1:0]         ptr_t;
    typedef logic [$clog2(depth+1)-1:0]   count_t;

    payload_t mem [depth];
    ptr_t     rd_ptr;
    ptr_t     wr_ptr;
    count_t   count;
    logic     do_push;
    logic     do_pop;

    assign empty    = (count == '0);
    assign full     = (count == count_t'(depth));
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + count_t'(do_push) - count_t'(do_pop);
        end
    end

    // storage, no reset
    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end
endmodule

// File: issue_unit.sv
// in-order issue queue
module issue_unit #(
    parameter int unsigned queue_depth = 8,
    parameter int unsigned lane_count  = 2
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     squash,
    input  logic                     dispatch_valid,
    input  isa_pkg::op_t             dispatch_op,
    input  logic [isa_pkg::xlen-1:0] dispatch_a,
    input  logic [isa_pkg::xlen-1:0] dispatch_b,
    input  logic [isa_pkg::xlen-1:0] dispatch_pc,
    input  rob_pkg::rob_tag_t        alloc_tag,
    exec_if.sender                   lanes [lane_count]
);
    rob_pkg::issue_packet_t push_packet;
    rob_pkg::issue_packet_t head_packet;
    logic                   queue_empty;
    logic                   queue_full;
    logic [lane_count-1:0]  lane_idle;
    logic                   send;
    int unsigned            sel;

    // tag comes from the reorder buffer tail
    assign push_packet = '{
        tag: alloc_tag,
        op:  dispatch_op,
        a:   dispatch_a,
        b:   dispatch_b,
        pc:  dispatch_pc
    };

    fifo_buffer #(
        .depth     (queue_depth),
        .payload_t (rob_pkg::issue_packet_t)
    ) i_queue (
        .clock     (clock),
        .reset     (reset),
        .flush     (squash),
        .push      (dispatch_valid && !queue_full),
        .push_data (push_packet),
        .pop       (send),
        .pop_data  (head_packet),
        .empty     (queue_empty),
        .full      (queue_full)
    );

    // lowest numbered idle lane wins
    always_comb begin
        sel = 0;
        for (int i = lane_count - 1; i >= 0; i--) begin
            if (lane_idle[i]) begin
                sel = i;
            end
        end
    end

    assign send = !queue_empty && (lane_idle != '0);

    for (genvar g = 0; g < lane_count; g++) begin : g_lane
        assign lane_idle[g]     = lanes[g].idle;
        assign lanes[g].valid  = send && (sel == g);
        assign lanes[g].packet = head_packet;
    end
endmodule

// File: exec_lane.sv
// integer execution lane
module exec_lane #(
    parameter int unsigned mul_latency = 3,
    parameter int unsigned lane_index  = 0
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   squash,
    exec_if.lane   issue,
    cdb_if.lane    result
);
    localparam bit mul_stalls = (mul_latency > 1);

    rob_pkg::issue_packet_t        held_packet;
    rob_pkg::issue_packet_t        src_packet;
    logic [$clog2(mul_latency+1)-1:0] count;
    logic                          busy;
    logic                          take;
    logic                          start_mul;
    logic                          finish;
    logic                          hold_empty;
    logic                          hold_full;

    function automatic isa_pkg::lane_result_t compute(rob_pkg::issue_packet_t p);
        isa_pkg::lane_result_t r;
        r.tag    = p.tag;
        r.taken  = 1'b0;
        r.target = '0;
        case (p.op)
            isa_pkg::op_add: r.value = p.a + p.b;
            isa_pkg::op_sub: r.value = p.a - p.b;
            isa_pkg::op_xor: r.value = p.a ^ p.b;
            // low half of the product
            isa_pkg::op_mul: r.value = p.a * p.b;
            isa_pkg::op_bnez: begin
                r.value  = p.pc + 32'd4;
                r.taken  = (p.a != '0);
                r.target = p.pc + p.b;
            end
            default: r.value = '0;
        endcase
        return r;
    endfunction

    assign issue.idle = !busy && !hold_full;
    assign take       = issue.valid && issue.idle && !squash;
    assign start_mul  = take && mul_stalls && (issue.packet.op == isa_pkg::op_mul);
    assign finish     = busy && (count == 1);
    assign src_packet = busy ? held_packet : issue.packet;

    //////////////////////////////////////////////////
    // multiply latency countdown
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start_mul) begin
            busy  <= 1'b1;
            count <= ($bits(count))'(mul_latency - 1);
        end else if (busy) begin
            busy  <= !finish;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (start_mul) begin
            held_packet <= issue.packet;
        end
    end

    // results wait here until granted
    fifo_buffer #(
        .depth     (2),
        .payload_t (isa_pkg::lane_result_t)
    ) i_hold (
        .clock     (clock),
        .reset     (reset),
        .flush     (squash),
        .push      ((take && !start_mul) || finish),
        .push_data (compute(src_packet)),
        .pop       (result.grant[lane_index]),
        .pop_data  (result.lane_data[lane_index]),
        .empty     (hold_empty),
        .full      (hold_full)
    );

    assign result.pending[lane_index] = !hold_empty;
endmodule

// File: cdb_arbiter.sv
// round-robin CDB arbiter
module cdb_arbiter #(
    parameter int unsigned lane_count = 2
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   squash,
    cdb_if.arbiter lanes
);
    localparam int unsigned ptr_width = (lane_count > 1) ? $clog2(lane_count) : 1;

    logic [ptr_width-1:0] ptr;
    int unsigned          sel;
    logic                 found;
    int unsigned          idx;

    // first pending lane at or after the pointer
    always_comb begin
        sel   = 0;
        found = 1'b0;
        idx   = 0;
        for (int unsigned k = 0; k < lane_count; k++) begin
            idx = (ptr + k) % lane_count;
            if (lanes.pending[idx] && !found) begin
                sel   = idx;
                found = 1'b1;
            end
        end
    end

    assign lanes.bus_valid = found;
    assign lanes.bus_data  = lanes.lane_data[sel];

    for (genvar g = 0; g < lane_count; g++) begin : g_grant
        assign lanes.grant[g] = found && (sel == g);
    end

    // the lane after the winner gets first pick next
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= (sel == lane_count - 1) ? '0 : ptr_width'(sel + 1);
        end
    end
endmodule

// File: rob.sv
// reorder buffer
module rob #(
    parameter int unsigned rob_depth = 8
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  isa_pkg::op_t             dispatch_op,
    input  logic [isa_pkg::xlen-1:0] dispatch_pc,
    input  isa_pkg::reg_idx_t        dispatch_dest,
    input  logic                     dispatch_pred_taken,
    cdb_if.sink                      cdb,
    output rob_pkg::rob_tag_t        alloc_tag,
    output logic                     rob_full,
    output logic                     retire_valid,
    output isa_pkg::reg_idx_t        retire_dest,
    output logic [isa_pkg::xlen-1:0] retire_value,
    output logic [isa_pkg::xlen-1:0] retire_pc,
    output logic                     squash,
    output logic [isa_pkg::xlen-1:0] squash_target,
    output logic                     halt
);
    typedef logic [$clog2(rob_depth+1)-1:0] count_t;

    rob_pkg::rob_entry_t entries [rob_depth];
    rob_pkg::rob_entry_t head_entry;
    rob_pkg::rob_tag_t   head;
    rob_pkg::rob_tag_t   tail;
    rob_pkg::rob_tag_t   cdb_tag;
    count_t              count;
    logic                halt_q;
    logic                accept;
    logic                actual_taken;

    assign head_entry = entries[head];
    assign cdb_tag    = cdb.bus_data.tag;
    assign alloc_tag  = tail;
    assign rob_full   = (count == count_t'(rob_depth));
    assign accept     = dispatch_valid && !rob_full && !halt_q;

    //////////////////////////////////////////////////
    // retire side
    //////////////////////////////////////////////////
    assign retire_valid = head_entry.valid && head_entry.ready && !halt_q;
    assign retire_dest  = head_entry.dest;
    assign retire_value = head_entry.value;
    assign retire_pc    = head_entry.pc;

    // mispredicted means the real outcome is the opposite of the guess
    assign actual_taken  = head_entry.pred_taken ^ head_entry.mispred;
    assign squash        = retire_valid && head_entry.mispred;
    assign squash_target = actual_taken ? head_entry.target : head_entry.pc + 32'd4;

    assign halt = halt_q || (retire_valid && head_entry.halt);

    always_ff @(posedge clock) begin
        if (reset) begin
            halt_q <= 1'b0;
        end else if (retire_valid && head_entry.halt) begin
            halt_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // allocate, write back, retire
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_depth; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (accept) begin
                entries[tail] <= '{
                    valid:      1'b1,
                    ready:      1'b0,
                    pc:         dispatch_pc,
                    dest:       dispatch_dest,
                    value:      '0,
                    pred_taken: dispatch_pred_taken && (dispatch_op == isa_pkg::op_bnez),
                    mispred:    1'b0,
                    target:     '0,
                    halt:       (dispatch_op == isa_pkg::op_halt)
                };
                tail <= (tail == rob_pkg::rob_tag_t'(rob_depth - 1)) ? '0 : tail + 1'b1;
            end

            // result from the common data bus
            if (cdb.bus_valid && entries[cdb_tag].valid) begin
                entries[cdb_tag].ready   <= 1'b1;
                entries[cdb_tag].value   <= cdb.bus_data.value;
                entries[cdb_tag].target  <= cdb.bus_data.target;
                entries[cdb_tag].mispred <= entries[cdb_tag].pred_taken ^ cdb.bus_data.taken;
            end

            if (retire_valid) begin
                entries[head].valid <= 1'b0;
                head <= (head == rob_pkg::rob_tag_t'(rob_depth - 1)) ? '0 : head + 1'b1;
            end

            count <= count + count_t'(accept) - count_t'(retire_valid);
        end
    end
endmodule

// File: ooo_backend.sv
// out-of-order back end top
module ooo_backend #(
    parameter int unsigned rob_depth   = 8,
    parameter int unsigned lane_count  = 2,
    parameter int unsigned mul_latency = 3
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  isa_pkg::op_t             dispatch_op,
    input  logic [isa_pkg::xlen-1:0] dispatch_a,
    input  logic [isa_pkg::xlen-1:0] dispatch_b,
    input  logic [isa_pkg::xlen-1:0] dispatch_pc,
    input  isa_pkg::reg_idx_t        dispatch_dest,
    input  logic                     dispatch_pred_taken,
    output logic                     rob_full,
    output logic                     retire_valid,
    output isa_pkg::reg_idx_t        retire_dest,
    output logic [isa_pkg::xlen-1:0] retire_value,
    output logic [isa_pkg::xlen-1:0] retire_pc,
    output logic                     squash,
    output logic [isa_pkg::xlen-1:0] squash_target,
    output logic                     halt
);
    // one queue slot per reorder buffer entry
    localparam int unsigned queue_depth = rob_depth;

    rob_pkg::rob_tag_t alloc_tag;

    exec_if                          lane_bus [lane_count] ();
    cdb_if #(.lane_count(lane_count)) cdb ();

    issue_unit #(
        .queue_depth (queue_depth),
        .lane_count  (lane_count)
    ) i_issue_unit (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_a     (dispatch_a),
        .dispatch_b     (dispatch_b),
        .dispatch_pc    (dispatch_pc),
        .alloc_tag      (alloc_tag),
        .lanes          (lane_bus)
    );

    for (genvar g = 0; g < lane_count; g++) begin : g_lane
        exec_lane #(
            .mul_latency (mul_latency),
            .lane_index  (g)
        ) i_exec_lane (
            .clock  (clock),
            .reset  (reset),
            .squash (squash),
            .issue  (lane_bus[g]),
            .result (cdb)
        );
    end

    cdb_arbiter #(
        .lane_count (lane_count)
    ) i_cdb_arbiter (
        .clock  (clock),
        .reset  (reset),
        .squash (squash),
        .lanes  (cdb)
    );

    rob #(
        .rob_depth (rob_depth)
    ) i_rob (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_op         (dispatch_op),
        .dispatch_pc         (dispatch_pc),
        .dispatch_dest       (dispatch_dest),
        .dispatch_pred_taken (dispatch_pred_taken),
        .cdb                 (cdb),
        .alloc_tag           (alloc_tag),
        .rob_full            (rob_full),
        .retire_valid        (retire_valid),
        .retire_dest         (retire_dest),
        .retire_value        (retire_value),
        .retire_pc           (retire_pc),
        .squash              (squash),
        .squash_target       (squash_target),
        .halt                (halt)
    );
endmodule

// File: ooo_backend_asserts.sv
// reorder buffer protocol assertions
module ooo_backend_asserts #(
    parameter int unsigned rob_depth = 8
) (
    input logic                clock,
    input logic                reset,
    input logic                dispatch_valid,
    input logic                rob_full,
    input logic                retire_valid,
    input logic                squash,
    input logic                cdb_valid,
    input rob_pkg::rob_tag_t   cdb_tag,
    input rob_pkg::rob_entry_t entries [rob_depth]
);
    // failed assertions so far
    int unsigned error_count = 0;

    assert property (@(posedge clock) disable iff (reset) !(dispatch_valid && rob_full))
        else begin
            error_count++;
            $error("dispatch while the reorder buffer is full");
        end

    // a squash retires its branch and leaves nothing in flight
    assert property (@(posedge clock) disable iff (reset)
        squash |-> retire_valid ##1 (!retire_valid && !cdb_valid))
        else begin
            error_count++;
            $error("squash without a retiring entry or with work left after it");
        end

    assert property (@(posedge clock) disable iff (reset) cdb_valid |-> entries[cdb_tag].valid)
        else begin
            error_count++;
            $error("common data bus write to an unallocated entry");
        end

    // entries are cleared by the first reset edge
    assert property (@(posedge clock) reset ##1 reset |-> !retire_valid)
        else begin
            error_count++;
            $error("retire_valid high during reset");
        end
endmodule

bind rob ooo_backend_asserts #(
    .rob_depth (rob_depth)
) i_rob_asserts (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .rob_full       (rob_full),
    .retire_valid   (retire_valid),
    .squash         (squash),
    .cdb_valid      (cdb.bus_valid),
    .cdb_tag        (cdb_tag),
    .entries        (entries)
);

// File: tb_ooo_backend.sv
// out-of-order back end testbench
module tb_ooo_backend;

    localparam int unsigned rob_depth   = 8;
    localparam int unsigned lane_count  = 2;
    localparam int unsigned mul_latency = 3;

    // one record of the cases file, fields in file order
    typedef struct packed {
        logic [7:0]       kind;
        logic [6:0][31:0] f;
    } case_t;

    logic                     clock;
    logic                     reset;
    logic                     dispatch_valid;
    isa_pkg::op_t             dispatch_op;
    logic [isa_pkg::xlen-1:0] dispatch_a;
    logic [isa_pkg::xlen-1:0] dispatch_b;
    logic [isa_pkg::xlen-1:0] dispatch_pc;
    isa_pkg::reg_idx_t        dispatch_dest;
    logic                     dispatch_pred_taken;
    logic                     rob_full;
    logic                     retire_valid;
    isa_pkg::reg_idx_t        retire_dest;
    logic [isa_pkg::xlen-1:0] retire_value;
    logic [isa_pkg::xlen-1:0] retire_pc;
    logic                     squash;
    logic [isa_pkg::xlen-1:0] squash_target;
    logic                     halt;

    case_t       drive_q [$];
    case_t       expect_q [$];
    int unsigned case_lines;
    int unsigned occ;
    int unsigned squash_count;
    int unsigned squash_wait;
    logic        reset_checked;
    logic        full_seen;
    logic        halt_seen;

    ooo_backend #(
        .rob_depth   (rob_depth),
        .lane_count  (lane_count),
        .mul_latency (mul_latency)
    ) i_ooo_backend (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_op         (dispatch_op),
        .dispatch_a          (dispatch_a),
        .dispatch_b          (dispatch_b),
        .dispatch_pc         (dispatch_pc),
        .dispatch_dest       (dispatch_dest),
        .dispatch_pred_taken (dispatch_pred_taken),
        .rob_full            (rob_full),
        .retire_valid        (retire_valid),
        .retire_dest         (retire_dest),
        .retire_value        (retire_value),
        .retire_pc           (retire_pc),
        .squash              (squash),
        .squash_target       (squash_target),
        .halt                (halt)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////
    task automatic report_mismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic report_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic run_watchdog(input int unsigned cycles);
        repeat (cycles) @(posedge clock);
        report_error($sformatf("timeout, the run did not finish within %0d cycles", cycles));
    endtask

    //////////////////////////////////////////////////
    // cases file
    //////////////////////////////////////////////////
    task automatic load_cases();
        int          fd;
        int          got;
        string       line;
        case_t       item;
        logic [7:0]  kind;
        logic [31:0] v [7];
        fd = $fopen("ooo_backend_cases.txt", "r");
        if (fd == 0) begin
            report_error("cannot open ooo_backend_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            // skip blank and comment lines
            if (got == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            for (int i = 0; i < 7; i++) begin
                v[i] = '0;
            end
            got = $sscanf(line, "%c %h %h %h %h %h %h %h",
                          kind, v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
            item.kind = kind;
            for (int i = 0; i < 7; i++) begin
                item.f[i] = v[i];
            end
            case_lines++;
            if (kind == "D") begin
                drive_q.push_back(item);
            end else if (kind == "S") begin
                // the driver also waits on it before the next dispatch
                drive_q.push_back(item);
                expect_q.push_back(item);
            end else if (kind == "R" || kind == "H") begin
                expect_q.push_back(item);
            end else begin
                report_error($sformatf("unknown record kind %c in the cases file", kind));
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic next_drive_slot();
        @(posedge clock);
        #10;
    endtask

    task automatic send_dispatch(input case_t item);
        int unsigned gap;
        // burst records go back to back
        gap = item.f[6][0] ? 0 : $urandom % 4;
        repeat (gap) next_drive_slot();
        while (rob_full) begin
            next_drive_slot();
        end
        dispatch_valid      = 1'b1;
        dispatch_op         = isa_pkg::op_t'(item.f[0][2:0]);
        dispatch_a          = item.f[1];
        dispatch_b          = item.f[2];
        dispatch_pc         = item.f[3];
        dispatch_dest       = item.f[4][4:0];
        dispatch_pred_taken = item.f[5][0];
        next_drive_slot();
        dispatch_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // response checking
    //////////////////////////////////////////////////
    task automatic take_expect(input logic [7:0] kind, output case_t item);
        assert (expect_q.size() != 0)
            else report_error($sformatf("event %c seen with no expected record left", kind));
        item = expect_q.pop_front();
        assert (item.kind == kind)
            else report_mismatch($sformatf("event %c seen where record %c is next",
                                           kind, item.kind));
    endtask

    task automatic check_cycle();
        case_t exp_item;
        if (!reset_checked) begin
            assert (!retire_valid && !squash && !halt && !rob_full)
                else report_error("outputs are not idle after reset");
            reset_checked = 1'b1;
        end
        // full exactly when every entry is in use
        assert (rob_full == (occ == rob_depth))
            else report_mismatch($sformatf("rob_full is %0b with %0d entries in use",
                                           rob_full, occ));
        if (rob_full) begin
            full_seen = 1'b1;
        end
        if (retire_valid) begin
            take_expect("R", exp_item);
            assert (retire_dest == exp_item.f[0][4:0] && retire_value == exp_item.f[1]
                    && retire_pc == exp_item.f[2])
                else report_mismatch($sformatf(
                    "retire dest %h value %h pc %h, expected dest %h value %h pc %h",
                    retire_dest, retire_value, retire_pc,
                    exp_item.f[0][4:0], exp_item.f[1], exp_item.f[2]));
        end
        if (squash) begin
            take_expect("S", exp_item);
            assert (squash_target == exp_item.f[0])
                else report_mismatch($sformatf("squash target %h, expected %h",
                                               squash_target, exp_item.f[0]));
            squash_count++;
        end
        if (halt && !halt_seen) begin
            take_expect("H", exp_item);
            assert (exp_item.f[0][0])
                else report_mismatch("halt rose where the cases file expects it low");
            halt_seen = 1'b1;
        end else if (halt_seen) begin
            assert (halt)
                else report_error("halt fell before reset");
        end
        // occupancy after the coming edge
        if (squash) begin
            occ = 0;
        end else begin
            occ = occ + int'(dispatch_valid && !rob_full && !halt) - int'(retire_valid);
        end
    endtask

    always @(negedge clock) begin
        // protocol assertions bound into the reorder buffer
        assert (i_ooo_backend.i_rob.i_rob_asserts.error_count == 0)
            else report_error("a protocol assertion in the reorder buffer failed");
        if (reset) begin
            occ = 0;
        end else begin
            check_cycle();
        end
    end

    initial begin
        void'($urandom(32'h7f926b90));
        reset               = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_op         = isa_pkg::op_add;
        dispatch_a          = '0;
        dispatch_b          = '0;
        dispatch_pc         = '0;
        dispatch_dest       = '0;
        dispatch_pred_taken = 1'b0;
        case_lines          = 0;
        occ                 = 0;
        squash_count        = 0;
        squash_wait         = 0;
        reset_checked       = 1'b0;
        full_seen           = 1'b0;
        halt_seen           = 1'b0;
        load_cases();
        fork
            run_watchdog(case_lines * 50);
        join_none
        repeat (8) @(posedge clock);
        #10;
        reset = 1'b0;
        foreach (drive_q[i]) begin
            if (drive_q[i].kind == "S") begin
                // resume only once the squash has gone by
                squash_wait++;
                while (squash_count < squash_wait) begin
                    next_drive_slot();
                end
            end else begin
                send_dispatch(drive_q[i]);
            end
        end
        while (expect_q.size() != 0) begin
            next_drive_slot();
        end
        // quiet period after halt
        repeat (20) next_drive_slot();
        if (full_seen) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_error("rob_full never rose during the run");
        end
    end
endmodule

// File: ooo_backend_cases.txt
# D op a b pc dest pred_taken burst, all hex, burst 1 = right after the previous dispatch
# R dest value pc / S squash_target / H halt, expected in retire order
D 0 00000005 00000003 00000100 01 0 0
D 1 00000010 00000003 00000104 02 0 0
D 2 0000ff00 00f0f0f0 00000108 03 0 0
D 1 00000003 00000005 0000010c 04 0 0
R 01 00000008 00000100
R 02 0000000d 00000104
R 03 00f00ff0 00000108
R 04 fffffffe 0000010c
# multiply ahead of quicker operations
D 3 00012345 00010000 00000110 05 0 0
D 0 00000001 00000001 00000114 06 0 1
D 2 ffffffff 0000000f 00000118 07 0 1
R 05 23450000 00000110
R 06 00000002 00000114
R 07 fffffff0 00000118
# correctly predicted branches
D 4 00000001 00000040 0000011c 08 1 0
D 4 00000000 00000040 00000120 09 0 0
R 08 00000120 0000011c
R 09 00000124 00000120
# predicted not taken, actually taken, two wrong-path instructions
D 4 00000007 00000100 00000124 0a 0 0
D 0 00000011 00000022 00000128 0b 0 1
D 2 00000033 00000044 0000012c 0c 0 1
R 0a 00000128 00000124
S 00000224
D 1 00000009 00000004 00000224 0d 0 0
R 0d 00000005 00000224
# predicted taken, actually not taken
D 4 00000000 00000010 00000228 0e 1 0
D 0 00000055 00000066 00000238 0b 0 1
D 3 00000077 00000088 0000023c 0c 0 1
R 0e 0000022c 00000228
S 0000022c
D 0 00000002 00000003 0000022c 0f 0 0
R 0f 00000005 0000022c
# multiply burst fills the reorder buffer
D 3 00000001 01000001 00000230 10 0 0
D 3 00000002 01000001 00000234 11 0 1
D 3 00000003 01000001 00000238 12 0 1
D 3 00000004 01000001 0000023c 13 0 1
D 3 00000005 01000001 00000240 14 0 1
D 3 00000006 01000001 00000244 15 0 1
D 3 00000007 01000001 00000248 16 0 1
D 3 00000008 01000001 0000024c 17 0 1
D 3 00000009 01000001 00000250 18 0 1
D 3 0000000a 01000001 00000254 19 0 1
D 3 0000000b 01000001 00000258 1a 0 1
D 3 0000000c 01000001 0000025c 1b 0 1
D 3 0000000d 01000001 00000260 1c 0 1
D 3 0000000e 01000001 00000264 1d 0 1
D 3 0000000f 01000001 00000268 1e 0 1
D 3 00000010 01000001 0000026c 1f 0 1
R 10 01000001 00000230
R 11 02000002 00000234
R 12 03000003 00000238
R 13 04000004 0000023c
R 14 05000005 00000240
R 15 06000006 00000244
R 16 07000007 00000248
R 17 08000008 0000024c
R 18 09000009 00000250
R 19 0a00000a 00000254
R 1a 0b00000b 00000258
R 1b 0c00000c 0000025c
R 1c 0d00000d 00000260
R 1d 0e00000e 00000264
R 1e 0f00000f 00000268
R 1f 10000010 0000026c
# halt, the add behind it never retires
D 5 00000000 00000000 00000270 00 0 0
D 0 00000001 00000001 00000274 01 0 1
R 00 00000000 00000270
H 1

// File: flist.f
isa_pkg.sv
rob_pkg.sv
backend_ifs.sv
fifo_buffer.sv
issue_unit.sv
exec_lane.sv
cdb_arbiter.sv
rob.sv
ooo_backend.sv
ooo_backend_asserts.sv
tb_ooo_backend.sv

// File: Bender.yml
package:
  name: ooo_backend

sources:
  - isa_pkg.sv
  - rob_pkg.sv
  - backend_ifs.sv
  - fifo_buffer.sv
  - issue_unit.sv
  - exec_lane.sv
  - cdb_arbiter.sv
  - rob.sv
  - ooo_backend.sv
  - target: test
    files:
      - ooo_backend_asserts.sv
      - tb_ooo_backend.sv
